// File: common/tile_pkg.sv
/*
 * Tile reduction package
 * Word type and tile geometry shared by the loader, reducer and top
 */
package tile_pkg;

  // Data word
  localparam int DATA_WIDTH = 32;
  typedef logic [DATA_WIDTH-1:0] word_t;

  // Tile geometry, row-major
  localparam int ROWS       = 4;
  localparam int COLS       = 4;
  localparam int TILE_WORDS = ROWS * COLS;

  // Counter and address widths
  localparam int ROW_W  = 2;
  localparam int COL_W  = 2;
  localparam int ADDR_W = ROW_W + COL_W;

endpackage

// File: hw/mem/seq_mem_d1.sv
/*
 * Single-port sequential memory
 * One-cycle reads and writes, each confirmed by a registered done pulse
 */
`timescale 1ns/1ps

module seq_mem_d1 #(
  parameter int WIDTH    = 32,
  parameter int SIZE     = 16,
  parameter int IDX_SIZE = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [IDX_SIZE-1:0] addr0,

  // Read side
  input  logic                read_en,
  output logic [WIDTH-1:0]    read_data,
  output logic                read_done,

  // Write side
  input  logic [WIDTH-1:0]    write_data,
  input  logic                write_en,
  output logic                write_done
);

  logic [WIDTH-1:0] mem [SIZE];

  // Registered read port
  always_ff @(posedge clk) begin
    if (reset) begin
      read_data <= '0;
    end else if (read_en) begin
      read_data <= mem[addr0];
    end else if (write_en) begin
      // Read output is undefined once a write has happened
      read_data <= 'x;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      read_done <= 1'b0;
    end else begin
      read_done <= read_en;
    end
  end

  // Storage array
  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[addr0] <= write_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      write_done <= 1'b0;
    end else begin
      write_done <= write_en;
    end
  end

  // Port is shared, so the two sides must take turns
  a_no_rw_overlap: assert property (
    @(posedge clk) disable iff (reset)
    !(read_en && write_en)
  ) else $error("seq_mem_d1: read and write in the same cycle");

  a_addr_in_range: assert property (
    @(posedge clk) disable iff (reset)
    (read_en || write_en) |-> (addr0 < SIZE)
  ) else $error("seq_mem_d1: address %0d out of range, size %0d", addr0, SIZE);

endmodule

// File: hw/tile_loader.sv
/*
 * Tile loader
 * Accepts a word stream and writes one tile into memory in row-major order
 */
`timescale 1ns/1ps

module tile_loader
  import tile_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              in_valid,
  input  word_t             in_data,
  output logic              in_ready,
  output logic [ADDR_W-1:0] wr_addr,
  output logic              write_en,
  output word_t             write_data,
  input  logic              write_done,
  input  logic              tile_release,
  output logic              tile_full
);

  logic [ADDR_W-1:0] wr_cnt;
  logic [ADDR_W-1:0] done_cnt;
  logic              tile_issued;
  logic              accept;

  // Input closes once all words of the tile are issued
  assign in_ready   = !tile_issued;
  assign accept     = in_valid && in_ready;
  assign write_en   = accept;
  assign wr_addr    = wr_cnt;
  assign write_data = in_data;

  // Issue side, one write per accepted word
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_cnt      <= '0;
      tile_issued <= 1'b0;
    end else begin
      if (accept) begin
        wr_cnt <= wr_cnt + 1'b1;
        if (wr_cnt == ADDR_W'(TILE_WORDS - 1)) begin
          tile_issued <= 1'b1;
        end
      end else if (tile_release) begin
        tile_issued <= 1'b0;
      end
    end
  end

  // Tile is full only once every write is confirmed
  always_ff @(posedge clk) begin
    if (reset) begin
      done_cnt  <= '0;
      tile_full <= 1'b0;
    end else begin
      if (write_done) begin
        done_cnt <= done_cnt + 1'b1;
        if (done_cnt == ADDR_W'(TILE_WORDS - 1)) begin
          tile_full <= 1'b1;
        end
      end else if (tile_release) begin
        tile_full <= 1'b0;
      end
    end
  end

  a_no_accept_when_full: assert property (
    @(posedge clk) disable iff (reset)
    tile_full |-> !(in_valid && in_ready)
  ) else $error("tile_loader: word accepted while tile is full");

endmodule

// File: hw/row_reducer.sv
/*
 * Row reducer
 * Reads the tile one row at a time and presents each row sum on a valid/ready port
 */
`timescale 1ns/1ps

module row_reducer
  import tile_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              tile_full,
  output logic [ADDR_W-1:0] rd_addr,
  output logic              read_en,
  input  word_t             read_data,
  input  logic              read_done,
  output logic              out_valid,
  output word_t             out_data,
  input  logic              out_ready,
  output logic              tile_release
);

  typedef enum logic [1:0] {
    st_idle,
    st_reading,
    st_draining,
    st_presenting
  } state_t;

  state_t           state;
  logic [ROW_W-1:0] row;
  logic [COL_W-1:0] col;
  word_t            acc;
  logic             last_col;
  logic             last_row;
  logic             transfer;

  assign last_col = (col == COL_W'(COLS - 1));
  assign last_row = (row == ROW_W'(ROWS - 1));
  assign transfer = out_valid && out_ready;

  assign read_en      = (state == st_reading);
  assign rd_addr      = {row, col};
  assign out_valid    = (state == st_presenting);
  assign out_data     = acc;
  // Hand the tile back to the loader with the last sum
  assign tile_release = transfer && last_row;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      row   <= '0;
      col   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (tile_full) begin
            row   <= '0;
            col   <= '0;
            state <= st_reading;
          end
        end
        st_reading: begin
          if (last_col) begin
            col   <= '0;
            state <= st_draining;
          end else begin
            col <= col + 1'b1;
          end
        end
        // Wait for the data of the last read in the row
        st_draining: begin
          if (read_done) begin
            state <= st_presenting;
          end
        end
        st_presenting: begin
          if (transfer) begin
            if (last_row) begin
              row   <= '0;
              state <= st_idle;
            end else begin
              row   <= row + 1'b1;
              state <= st_reading;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Row accumulator, wraps modulo 2^32
  always_ff @(posedge clk) begin
    if (state == st_idle || transfer) begin
      acc <= '0;
    end else if (read_done) begin
      acc <= acc + read_data;
    end
  end

  a_out_data_stable: assert property (
    @(posedge clk) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
  ) else $error("row_reducer: out_data changed while stalled");

endmodule

// File: hw/row_sum_top.sv
/*
 * Row sum engine top
 * Loader fills the tile memory, reducer drains it as row sums
 */
`timescale 1ns/1ps

module row_sum_top
  import tile_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  in_valid,
  input  word_t in_data,
  output logic  in_ready,
  output logic  out_valid,
  output word_t out_data,
  input  logic  out_ready
);

  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_addr;
  logic [ADDR_W-1:0] mem_addr;
  logic              write_en;
  word_t             write_data;
  logic              write_done;
  logic              read_en;
  word_t             read_data;
  logic              read_done;
  logic              tile_full;
  logic              tile_release;

  // Reducer owns the memory port while a full tile is held
  assign mem_addr = tile_full ? rd_addr : wr_addr;

  tile_loader u_loader (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_data      (in_data),
    .in_ready     (in_ready),
    .wr_addr      (wr_addr),
    .write_en     (write_en),
    .write_data   (write_data),
    .write_done   (write_done),
    .tile_release (tile_release),
    .tile_full    (tile_full)
  );

  seq_mem_d1 #(
    .WIDTH    (DATA_WIDTH),
    .SIZE     (TILE_WORDS),
    .IDX_SIZE (ADDR_W)
  ) u_mem (
    .clk        (clk),
    .reset      (reset),
    .addr0      (mem_addr),
    .read_en    (read_en),
    .read_data  (read_data),
    .read_done  (read_done),
    .write_data (write_data),
    .write_en   (write_en),
    .write_done (write_done)
  );

  row_reducer u_reducer (
    .clk          (clk),
    .reset        (reset),
    .tile_full    (tile_full),
    .rd_addr      (rd_addr),
    .read_en      (read_en),
    .read_data    (read_data),
    .read_done    (read_done),
    .out_valid    (out_valid),
    .out_data     (out_data),
    .out_ready    (out_ready),
    .tile_release (tile_release)
  );

endmodule

// File: verif/row_sum_checker.sv
/*
 * Row sum checker
 * Compares each transferred row sum with its expected value and watches both handshakes
 */
`timescale 1ns/1ps

module row_sum_checker
  import tile_pkg::*;
#(
  parameter int NUM_SUMS = 4
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  in_valid,
  input  logic  in_ready,
  input  logic  out_valid,
  input  word_t out_data,
  input  logic  out_ready,
  input  word_t expected_sum,
  output int    sum_count,
  output int    error_count
);

  int    word_count;
  logic  stalled;
  word_t held_data;
  logic  after_reset;

  always @(posedge clk) begin
    int   errs;
    logic exp_ready;
    errs = 0;
    // Loader holds off while a loaded tile still has sums pending
    exp_ready = !((word_count / TILE_WORDS) * ROWS > sum_count);
    if (reset) begin
      sum_count   <= 0;
      word_count  <= 0;
      error_count <= 0;
      stalled     <= 1'b0;
      after_reset <= 1'b1;
    end else begin
      after_reset <= 1'b0;
      if (after_reset && out_valid !== 1'b0) begin
        $display("ERROR out_valid after reset: expected 0, actual %h", out_valid);
        errs = errs + 1;
      end
      if (in_ready !== exp_ready) begin
        $display("ERROR in_ready: expected %h, actual %h", exp_ready, in_ready);
        errs = errs + 1;
      end
      // A stalled sum must stay put until it transfers
      if (stalled && out_valid !== 1'b1) begin
        $display("out_valid dropped before its sum was transferred");
        errs = errs + 1;
      end else if (stalled && out_data !== held_data) begin
        $display("ERROR out_data: stalled value %h, actual %h", held_data, out_data);
        errs = errs + 1;
      end
      if (in_valid && in_ready) begin
        word_count <= word_count + 1;
      end
      if (out_valid && out_ready) begin
        if (sum_count >= NUM_SUMS) begin
          $display("an extra row sum was transferred after the last tile");
          errs = errs + 1;
        end else if (out_data !== expected_sum) begin
          $display("ERROR out_data: sum %0d expected %h, actual %h",
                   sum_count, expected_sum, out_data);
          errs = errs + 1;
        end
        sum_count <= sum_count + 1;
      end
      stalled     <= out_valid && !out_ready;
      held_data   <= out_data;
      error_count <= error_count + errs;
    end
  end

endmodule

// File: verif/tb_row_sum.sv
/*
 * Row sum engine testbench
 * Streams tiles from the data file and checks the row sums under random back-pressure
 */
`timescale 1ns/1ps

module tb_row_sum
  import tile_pkg::*;
();

  localparam int NUM_TESTS   = 6;
  localparam int TEST_WORDS  = TILE_WORDS + ROWS;
  localparam int NUM_SUMS    = NUM_TESTS * ROWS;
  localparam int WAIT_CYCLES = 1000;

  logic        clk;
  logic        reset;
  logic        in_valid;
  word_t       in_data;
  logic        in_ready;
  logic        out_valid;
  word_t       out_data;
  logic        out_ready;
  logic        stall_en;
  word_t       vectors [NUM_TESTS * TEST_WORDS];
  word_t       expected_sum;
  int          sum_count;
  int          error_count;
  int          tests_passed;
  logic        timed_out;
  logic        load_error;

  always #4 clk = ~clk;

  // Random back-pressure drops out_ready about one cycle in four
  initial begin
    void'($urandom(27892));
    forever begin
      @(posedge clk);
      #1;
      if (stall_en) begin
        out_ready = ($urandom % 4) != 0;
      end
    end
  end

  assign expected_sum = vectors[(sum_count / ROWS) * TEST_WORDS + TILE_WORDS + sum_count % ROWS];

  row_sum_top u_dut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready)
  );

  row_sum_checker #(
    .NUM_SUMS (NUM_SUMS)
  ) u_checker (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .out_valid    (out_valid),
    .out_data     (out_data),
    .out_ready    (out_ready),
    .expected_sum (expected_sum),
    .sum_count    (sum_count),
    .error_count  (error_count)
  );

  // Hold one word on the input until the loader takes it
  task automatic send_word(input word_t data);
    int   cycles;
    logic taken;
    cycles   = 0;
    taken    = 1'b0;
    in_valid = 1'b1;
    in_data  = data;
    while (!taken && !timed_out) begin
      @(negedge clk);
      if (in_ready) begin
        @(posedge clk);
        #1;
        taken = 1'b1;
      end else begin
        cycles = cycles + 1;
        if (cycles >= WAIT_CYCLES) begin
          $display("timeout: input word %h not accepted in %0d cycles", data, WAIT_CYCLES);
          timed_out = 1'b1;
        end
      end
    end
  endtask

  task automatic wait_sums(input int target);
    int cycles;
    cycles = 0;
    while (sum_count < target && !timed_out) begin
      @(posedge clk);
      #1;
      cycles = cycles + 1;
      if (sum_count < target && cycles >= WAIT_CYCLES) begin
        $display("timeout: row sum %0d did not arrive in %0d cycles", sum_count, WAIT_CYCLES);
        timed_out = 1'b1;
      end
    end
  endtask

  initial begin
    int errors_before;
    int test_errors;
    clk          = 1'b0;
    reset        = 1'b1;
    in_valid     = 1'b0;
    in_data      = '0;
    out_ready    = 1'b0;
    stall_en     = 1'b0;
    timed_out    = 1'b0;
    load_error   = 1'b0;
    tests_passed = 0;
    $readmemh("verif/row_sum_input.txt", vectors);
    for (int i = 0; i < NUM_TESTS * TEST_WORDS; i++) begin
      if ($isunknown(vectors[i])) begin
        load_error = 1'b1;
      end
    end
    if (load_error) begin
      $display("data file verif/row_sum_input.txt is missing or incomplete");
    end

    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    // One idle cycle so the checker sees the state right after reset
    @(posedge clk);
    #1;
    stall_en = 1'b1;

    fork
      begin
        // Tiles go back to back and each word waits on in_ready
        for (int t = 0; t < NUM_TESTS; t++) begin
          for (int w = 0; w < TILE_WORDS; w++) begin
            if (!timed_out) begin
              send_word(vectors[t * TEST_WORDS + w]);
            end
          end
        end
        in_valid = 1'b0;
      end
      begin
        errors_before = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
          wait_sums((t + 1) * ROWS);
          test_errors   = error_count - errors_before;
          errors_before = error_count;
          if (!timed_out && test_errors == 0) begin
            tests_passed = tests_passed + 1;
            $display("test %0d: pass", t);
          end else begin
            $display("test %0d: fail, %0d errors", t, test_errors);
          end
        end
      end
    join

    // Quiet period to catch any stray sum
    repeat (10) @(posedge clk);
    #1;
    $display("%0d of %0d tests passed, %0d check errors", tests_passed, NUM_TESTS, error_count);
    if (!timed_out && !load_error && error_count == 0 && tests_passed == NUM_TESTS) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: verif/row_sum_input.txt
// Row sum vectors, one tile per block: four lines of input words in row-major order,
// then one line with the four expected row sums modulo 2^32
// test 0: small values
00000001 00000002 00000003 00000004
00000010 00000020 00000030 00000040
00000100 00000200 00000300 00000400
00001000 00002000 00003000 00004000
0000000a 000000a0 00000a00 0000a000
// test 1: rows that overflow 32 bits
ffffffff 00000001 00000000 00000000
80000000 80000000 00000005 00000000
ffffffff ffffffff ffffffff ffffffff
7fffffff 7fffffff 00000003 00000000
00000000 00000005 fffffffc 00000001
// test 2: sparse rows
00000000 00000000 00000000 00000000
12345678 00000000 00000000 00000000
00000000 00000000 00000000 deadbeef
11111111 22222222 33333333 44444444
00000000 12345678 deadbeef aaaaaaaa
// test 3: bit patterns
01010101 02020202 04040404 08080808
f0000000 0f000000 00f00000 000f0000
0000000f 000000f0 00000f00 0000f000
89abcdef 76543210 00000001 00000000
0f0f0f0f ffff0000 0000ffff 00000000
// test 4: mixed wrap and no wrap
00000001 00000001 00000001 00000001
aaaaaaaa 55555555 00000000 00000001
40000001 40000001 40000001 40000001
00001000 00002000 00004000 00008000
00000004 00000000 00000004 0000f000
// test 5: carries across nibbles
13579bdf 02468ace 00000000 00000000
0000ffff 0000ffff 0000ffff 0000ffff
fffffffe 00000001 00000001 00000001
00000100 00000200 00000300 00000400
159e26ad 0003fffc 00000001 00000a00

// File: compile.f
common/tile_pkg.sv
hw/mem/seq_mem_d1.sv
hw/tile_loader.sv
hw/row_reducer.sv
hw/row_sum_top.sv
verif/row_sum_checker.sv
verif/tb_row_sum.sv

// File: Bender.yml
package:
  name: row_sum

sources:
  - common/tile_pkg.sv
  - hw/mem/seq_mem_d1.sv
  - hw/tile_loader.sv
  - hw/row_reducer.sv
  - hw/row_sum_top.sv
  - target: test
    files:
      - verif/row_sum_checker.sv
      - verif/tb_row_sum.sv
